/* mp_settings.svh */
`ifndef MP_SETTINGS_SVH
`define MP_SETTINGS_SVH

`define MP_WIDTH   16                 // data word width.
`define MP_NUMVROW 16
`define MP_BITVROW 4
`define MP_NUMVBNK 4
`define MP_BITVBNK 2
`define MP_NUMPBNK (`MP_NUMVBNK + 1)  // one spare bank per row.
`define MP_BITPBNK 3
// address is {row, vbank}.
`define MP_BITADDR 6

`endif

/* mp_pkg.sv */
`default_nettype none

`include "mp_settings.svh"

package mp_pkg;

  // map table start-up sequence.
  typedef enum logic {
    ST_INIT,  // writing the identity map.
    ST_RUN
  } init_state_t;

  // physical bank id, covers the spare bank.
  typedef logic [`MP_BITPBNK-1:0] pbank_t;

endpackage

`default_nettype wire

/* mp_bank_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_bank_ram (
  input  wire                     clk,
  input  wire                     we,
  input  wire [`MP_BITVROW-1:0]   wadr,
  input  wire [`MP_WIDTH-1:0]     wdat,
  input  wire                     re,
  input  wire [`MP_BITVROW-1:0]   radr,
  output logic [`MP_WIDTH-1:0]    rdat
);

  logic [`MP_WIDTH-1:0] mem [`MP_NUMVROW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wadr] <= wdat;
    end
  end

  // same-row read during a write returns the old word.
  always_ff @(posedge clk) begin
    if (re) begin
      rdat <= mem[radr];
    end
  end

endmodule

`default_nettype wire

/* mp_map_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_map_table
  import mp_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  output logic                    ready,

  input  wire [`MP_BITVROW-1:0]   wl_row0,
  input  wire [`MP_BITVROW-1:0]   wl_row1,
  input  wire [`MP_BITVBNK-1:0]   wl_vbnk0,
  input  wire [`MP_BITVBNK-1:0]   wl_vbnk1,
  output pbank_t                  wl_pbnk0,
  output pbank_t                  wl_pbnk1,
  output pbank_t                  wl_free1,

  input  wire [`MP_BITVROW-1:0]   rl_row0,
  input  wire [`MP_BITVROW-1:0]   rl_row1,
  input  wire [`MP_BITVBNK-1:0]   rl_vbnk0,
  input  wire [`MP_BITVBNK-1:0]   rl_vbnk1,
  output pbank_t                  rl_pbnk0,
  output pbank_t                  rl_pbnk1,

  input  wire                     remap,
  input  wire [`MP_BITVROW-1:0]   remap_row,
  input  wire [`MP_BITVBNK-1:0]   remap_vbnk,
  input  pbank_t                  remap_pbnk
);

  init_state_t state_q;
  logic [`MP_BITVROW-1:0] init_row_q;

  pbank_t map_q  [`MP_NUMVROW][`MP_NUMVBNK];  // vbank to pbank, per row.
  pbank_t free_q [`MP_NUMVROW];               // unmapped pbank, per row.

  logic init_last;

  assign init_last = (init_row_q == `MP_BITVROW'(`MP_NUMVROW - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_INIT;
      init_row_q <= '0;
    end else begin
      case (state_q)
        ST_INIT: begin
          init_row_q <= init_row_q + 1'b1;
          if (init_last) begin
            state_q <= ST_RUN;
          end
        end
        ST_RUN: begin
          state_q <= ST_RUN;
        end
        default: begin
          state_q <= ST_INIT;
        end
      endcase
    end
  end

  assign ready = (state_q == ST_RUN);

  // identity map first, then the vbank and the free bank trade places.
  always_ff @(posedge clk) begin
    if (state_q == ST_INIT) begin
      for (int v = 0; v < `MP_NUMVBNK; v++) begin
        map_q[init_row_q][v] <= pbank_t'(v);
      end
      free_q[init_row_q] <= pbank_t'(`MP_NUMVBNK);
    end else if (remap) begin
      map_q[remap_row][remap_vbnk] <= remap_pbnk;
      free_q[remap_row]            <= map_q[remap_row][remap_vbnk];
    end
  end

  assign wl_pbnk0 = map_q[wl_row0][wl_vbnk0];
  assign wl_pbnk1 = map_q[wl_row1][wl_vbnk1];
  assign wl_free1 = free_q[wl_row1];

  assign rl_pbnk0 = map_q[rl_row0][rl_vbnk0];
  assign rl_pbnk1 = map_q[rl_row1][rl_vbnk1];

endmodule

`default_nettype wire

/* mp_write_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_write_stage
  import mp_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     write0,
  input  wire                     write1,
  input  wire [`MP_BITADDR-1:0]   wr_adr0,
  input  wire [`MP_BITADDR-1:0]   wr_adr1,
  input  wire [`MP_WIDTH-1:0]     din0,
  input  wire [`MP_WIDTH-1:0]     din1,

  output logic [`MP_BITVROW-1:0]  wl_row0,
  output logic [`MP_BITVROW-1:0]  wl_row1,
  output logic [`MP_BITVBNK-1:0]  wl_vbnk0,
  output logic [`MP_BITVBNK-1:0]  wl_vbnk1,
  input  pbank_t                  wl_pbnk0,
  input  pbank_t                  wl_pbnk1,
  input  pbank_t                  wl_free1,

  output logic                    remap,
  output logic [`MP_BITVROW-1:0]  remap_row,
  output logic [`MP_BITVBNK-1:0]  remap_vbnk,
  output pbank_t                  remap_pbnk,

  output logic [`MP_NUMPBNK-1:0]                   bk_we,
  output logic [`MP_NUMPBNK-1:0][`MP_BITVROW-1:0]  bk_wadr,
  output logic [`MP_NUMPBNK-1:0][`MP_WIDTH-1:0]    bk_wdat
);

  logic                   w0_vld_q, w1_vld_q;
  logic [`MP_BITADDR-1:0] w0_adr_q, w1_adr_q;
  logic [`MP_WIDTH-1:0]   w0_dat_q, w1_dat_q;

  logic   w0_en;
  logic   conflict;
  pbank_t w1_pbnk;

  always_ff @(posedge clk) begin
    if (rst) begin
      w0_vld_q <= 1'b0;
      w1_vld_q <= 1'b0;
    end else begin
      w0_vld_q <= write0;
      w1_vld_q <= write1;
    end
  end

  always_ff @(posedge clk) begin
    w0_adr_q <= wr_adr0;
    w1_adr_q <= wr_adr1;
    w0_dat_q <= din0;
    w1_dat_q <= din1;
  end

  assign wl_row0  = w0_adr_q[`MP_BITADDR-1:`MP_BITVBNK];
  assign wl_row1  = w1_adr_q[`MP_BITADDR-1:`MP_BITVBNK];
  assign wl_vbnk0 = w0_adr_q[`MP_BITVBNK-1:0];
  assign wl_vbnk1 = w1_adr_q[`MP_BITVBNK-1:0];

  assign w0_en    = w0_vld_q && !(w1_vld_q && (w0_adr_q == w1_adr_q));  // port 1 wins.
  assign conflict = w0_en && w1_vld_q && (wl_pbnk0 == wl_pbnk1);
  assign w1_pbnk  = conflict ? wl_free1 : wl_pbnk1;  // spare bank of row 1.

  assign remap      = conflict;
  assign remap_row  = wl_row1;
  assign remap_vbnk = wl_vbnk1;
  assign remap_pbnk = wl_free1;

  always_comb begin
    for (int b = 0; b < `MP_NUMPBNK; b++) begin
      bk_we[b]   = 1'b0;
      bk_wadr[b] = wl_row0;
      bk_wdat[b] = w0_dat_q;
      if (w0_en && (wl_pbnk0 == pbank_t'(b))) begin
        bk_we[b] = 1'b1;
      end
      if (w1_vld_q && (w1_pbnk == pbank_t'(b))) begin
        bk_we[b]   = 1'b1;
        bk_wadr[b] = wl_row1;
        bk_wdat[b] = w1_dat_q;
      end
    end
  end

endmodule

`default_nettype wire

/* mp_read_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_read_stage
  import mp_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     read0,
  input  wire                     read1,
  input  wire [`MP_BITADDR-1:0]   rd_adr0,
  input  wire [`MP_BITADDR-1:0]   rd_adr1,

  output logic [`MP_BITVROW-1:0]  rl_row0,
  output logic [`MP_BITVROW-1:0]  rl_row1,
  output logic [`MP_BITVBNK-1:0]  rl_vbnk0,
  output logic [`MP_BITVBNK-1:0]  rl_vbnk1,
  input  pbank_t                  rl_pbnk0,
  input  pbank_t                  rl_pbnk1,

  output logic [1:0][`MP_NUMPBNK-1:0]                   bk_re,
  output logic [1:0][`MP_NUMPBNK-1:0][`MP_BITVROW-1:0]  bk_radr,
  input  wire  [1:0][`MP_NUMPBNK-1:0][`MP_WIDTH-1:0]    bk_rdat,

  output logic                    rd_vld0,
  output logic                    rd_vld1,
  output logic [`MP_WIDTH-1:0]    rd_dout0,
  output logic [`MP_WIDTH-1:0]    rd_dout1
);

  logic [1:0]             vld_q;      // request registered.
  logic [1:0]             out_vld_q;  // bank data registered.
  logic [`MP_BITADDR-1:0] adr_q [2];
  pbank_t                 sel_q [2];
  pbank_t                 pbnk  [2];
  logic [1:0][`MP_WIDTH-1:0] dout;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q     <= '0;
      out_vld_q <= '0;
    end else begin
      vld_q     <= {read1, read0};
      out_vld_q <= vld_q;
    end
  end

  always_ff @(posedge clk) begin
    adr_q[0] <= rd_adr0;
    adr_q[1] <= rd_adr1;
    sel_q[0] <= pbnk[0];
    sel_q[1] <= pbnk[1];
  end

  assign rl_row0  = adr_q[0][`MP_BITADDR-1:`MP_BITVBNK];
  assign rl_row1  = adr_q[1][`MP_BITADDR-1:`MP_BITVBNK];
  assign rl_vbnk0 = adr_q[0][`MP_BITVBNK-1:0];
  assign rl_vbnk1 = adr_q[1][`MP_BITVBNK-1:0];

  assign pbnk[0] = rl_pbnk0;
  assign pbnk[1] = rl_pbnk1;

  // port p owns copy p, so the two reads never share a bank.
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      for (int b = 0; b < `MP_NUMPBNK; b++) begin
        bk_re[p][b]   = vld_q[p] && (pbnk[p] == pbank_t'(b));
        bk_radr[p][b] = adr_q[p][`MP_BITADDR-1:`MP_BITVBNK];
      end
    end
  end

  always_comb begin
    dout = '0;
    for (int p = 0; p < 2; p++) begin
      for (int b = 0; b < `MP_NUMPBNK; b++) begin
        if (sel_q[p] == pbank_t'(b)) begin
          dout[p] = bk_rdat[p][b];
        end
      end
    end
  end

  assign rd_vld0  = out_vld_q[0];
  assign rd_vld1  = out_vld_q[1];
  assign rd_dout0 = dout[0];
  assign rd_dout1 = dout[1];

endmodule

`default_nettype wire

/* mp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_top
  import mp_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  output logic                    ready,

  input  wire                     write0,
  input  wire                     write1,
  input  wire [`MP_BITADDR-1:0]   wr_adr0,
  input  wire [`MP_BITADDR-1:0]   wr_adr1,
  input  wire [`MP_WIDTH-1:0]     din0,
  input  wire [`MP_WIDTH-1:0]     din1,

  input  wire                     read0,
  input  wire                     read1,
  input  wire [`MP_BITADDR-1:0]   rd_adr0,
  input  wire [`MP_BITADDR-1:0]   rd_adr1,
  output logic                    rd_vld0,
  output logic                    rd_vld1,
  output logic [`MP_WIDTH-1:0]    rd_dout0,
  output logic [`MP_WIDTH-1:0]    rd_dout1
);

  logic [`MP_BITVROW-1:0] wl_row0, wl_row1, rl_row0, rl_row1, remap_row;
  logic [`MP_BITVBNK-1:0] wl_vbnk0, wl_vbnk1, rl_vbnk0, rl_vbnk1, remap_vbnk;
  pbank_t wl_pbnk0, wl_pbnk1, wl_free1, rl_pbnk0, rl_pbnk1, remap_pbnk;
  logic   remap;

  logic [`MP_NUMPBNK-1:0]                        bk_we;
  logic [`MP_NUMPBNK-1:0][`MP_BITVROW-1:0]       bk_wadr;
  logic [`MP_NUMPBNK-1:0][`MP_WIDTH-1:0]         bk_wdat;
  logic [1:0][`MP_NUMPBNK-1:0]                   bk_re;
  logic [1:0][`MP_NUMPBNK-1:0][`MP_BITVROW-1:0]  bk_radr;
  logic [1:0][`MP_NUMPBNK-1:0][`MP_WIDTH-1:0]    bk_rdat;

  mp_map_table u_map (
    .clk, .rst, .ready,
    .wl_row0, .wl_row1, .wl_vbnk0, .wl_vbnk1, .wl_pbnk0, .wl_pbnk1, .wl_free1,
    .rl_row0, .rl_row1, .rl_vbnk0, .rl_vbnk1, .rl_pbnk0, .rl_pbnk1,
    .remap, .remap_row, .remap_vbnk, .remap_pbnk
  );

  mp_write_stage u_wr (
    .clk, .rst, .write0, .write1, .wr_adr0, .wr_adr1, .din0, .din1,
    .wl_row0, .wl_row1, .wl_vbnk0, .wl_vbnk1, .wl_pbnk0, .wl_pbnk1, .wl_free1,
    .remap, .remap_row, .remap_vbnk, .remap_pbnk,
    .bk_we, .bk_wadr, .bk_wdat
  );

  mp_read_stage u_rd (
    .clk, .rst, .read0, .read1, .rd_adr0, .rd_adr1,
    .rl_row0, .rl_row1, .rl_vbnk0, .rl_vbnk1, .rl_pbnk0, .rl_pbnk1,
    .bk_re, .bk_radr, .bk_rdat,
    .rd_vld0, .rd_vld1, .rd_dout0, .rd_dout1
  );

  // one copy per read port; both copies take every write.
  for (genvar c = 0; c < 2; c++) begin : g_copy
    for (genvar b = 0; b < `MP_NUMPBNK; b++) begin : g_bank
      mp_bank_ram u_bank (
        .clk  (clk),
        .we   (bk_we[b]),
        .wadr (bk_wadr[b]),
        .wdat (bk_wdat[b]),
        .re   (bk_re[c][b]),
        .radr (bk_radr[c][b]),
        .rdat (bk_rdat[c][b])
      );
    end
  end

endmodule

`default_nettype wire

/* mp_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_properties
  import mp_pkg::*;
(
  input wire                    clk,
  input wire                    rst,
  input wire                    ready,
  input wire                    read0,
  input wire                    read1,
  input wire                    rd_vld0,
  input wire                    rd_vld1,
  input wire                    write0,
  input wire                    write1,
  input wire [`MP_NUMPBNK-1:0]  bk_we
);

  init_state_t phase;

  assign phase = ready ? ST_RUN : ST_INIT;

  // rd_vld is sampled high two edges after its strobe.
  rd_lat0: assert property (@(posedge clk) disable iff (rst) rd_vld0 == $past(read0, 2))
    else $error("read port 0 valid does not follow its strobe by the fixed latency");
  rd_lat1: assert property (@(posedge clk) disable iff (rst) rd_vld1 == $past(read1, 2))
    else $error("read port 1 valid does not follow its strobe by the fixed latency");

  no_vld_init: assert property (@(posedge clk) disable iff (rst)
    phase == ST_INIT |-> !(rd_vld0 || rd_vld1))
    else $error("read valid seen while the map table is initialising");

  // bank writes come from requests sampled on the previous edge.
  one_write: assert property (@(posedge clk) disable iff (rst)
    $countones(bk_we) <= int'($past(write0, 1)) + int'($past(write1, 1)))
    else $error("more bank writes than sampled write requests");

endmodule

bind mp_top mp_properties u_props (
  .clk, .rst, .ready, .read0, .read1, .rd_vld0, .rd_vld1, .write0, .write1, .bk_we
);

`default_nettype wire

/* mp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_tb;

  localparam int W        = `MP_WIDTH;
  localparam int AW       = `MP_BITADDR;
  localparam int NUM_ADDR = `MP_NUMVROW * `MP_NUMVBNK;

  typedef struct {
    string          name;
    bit             w0;
    logic [AW-1:0]  wa0;
    logic [W-1:0]   d0;
    bit             w1;
    logic [AW-1:0]  wa1;
    logic [W-1:0]   d1;
    bit             r0;
    logic [AW-1:0]  ra0;
    bit             r1;
    logic [AW-1:0]  ra1;
  } step_t;

  logic          clk;
  logic          rst;
  logic          ready;
  logic          write0, write1, read0, read1;
  logic [AW-1:0] wr_adr0, wr_adr1, rd_adr0, rd_adr1;
  logic [W-1:0]  din0, din1;
  logic          rd_vld0, rd_vld1;
  logic [W-1:0]  rd_dout0, rd_dout1;

  step_t         steps[$];
  logic [W-1:0]  model [NUM_ADDR];   // expected memory contents.
  logic [W-1:0]  exp_q0[$];
  logic [W-1:0]  exp_q1[$];
  logic [31:0]   seed = 32'hc487;
  string         cur_name = "init";
  int            n_tests = 0;
  int            test_checks = 0;
  int            test_err = 0;
  int            checks_total = 0;
  int            err_total = 0;
  bit            table_built = 0;

  mp_top dut0 (
    .clk, .rst, .ready,
    .write0, .write1, .wr_adr0, .wr_adr1, .din0, .din1,
    .read0, .read1, .rd_adr0, .rd_adr1,
    .rd_vld0, .rd_vld1, .rd_dout0, .rd_dout1
  );

  always #50 clk = ~clk;

  function automatic logic [W-1:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[31:16];
  endfunction

  task automatic add_step(input string name, input bit w0, input int a0, input logic [W-1:0] d0,
                          input bit w1, input int a1, input logic [W-1:0] d1,
                          input bit r0, input int ra0, input bit r1, input int ra1);
    step_t s;
    if (steps.size() == 0 || steps[$].name != name) begin
      n_tests++;
    end
    s.name = name;
    s.w0   = w0;
    s.wa0  = AW'(a0);
    s.d0   = d0;
    s.w1   = w1;
    s.wa1  = AW'(a1);
    s.d1   = d1;
    s.r0   = r0;
    s.ra0  = AW'(ra0);
    s.r1   = r1;
    s.ra1  = AW'(ra1);
    steps.push_back(s);
  endtask

  // port 0 walks up while port 1 walks down.
  task automatic add_read_all(input string name);
    for (int i = 0; i < NUM_ADDR; i++) begin
      add_step(name, 0, 0, '0, 0, 0, '0, 1, i, 1, NUM_ADDR - 1 - i);
    end
  endtask

  task automatic build_table();
    int v;
    logic [W-1:0] r0;
    logic [W-1:0] r1;
    // low bits carry the address so every word differs.
    for (int i = 0; i < NUM_ADDR; i += 2) begin
      r0 = next_rand();
      r1 = next_rand();
      add_step("readback", 1, i, {r0[W-1:AW], AW'(i)}, 1, i + 1, {r1[W-1:AW], AW'(i + 1)},
               0, 0, 0, 0);
    end
    add_read_all("readback");
    // same vbank, different rows, so the spare bank keeps moving.
    for (int k = 0; k < 24; k++) begin
      v = k % `MP_NUMVBNK;
      add_step("conflict", 1, (k % `MP_NUMVROW) * `MP_NUMVBNK + v, next_rand(),
               1, ((5 * k + 3) % `MP_NUMVROW) * `MP_NUMVBNK + v, next_rand(), 0, 0, 0, 0);
    end
    add_read_all("conflict");
    add_step("same_addr", 1, 21, next_rand(), 1, 21, next_rand(), 0, 0, 0, 0);
    add_step("same_addr", 0, 0, '0, 0, 0, '0, 1, 21, 1, 21);
    add_step("ordering", 1, 9, next_rand(), 0, 0, '0, 1, 9, 0, 0);
    add_step("ordering", 0, 0, '0, 1, 9, next_rand(), 1, 9, 1, 9);
    add_step("ordering", 0, 0, '0, 0, 0, '0, 1, 9, 1, 9);
    for (int k = 0; k < 200; k++) begin
      add_step("random", 1, int'(next_rand()) % NUM_ADDR, next_rand(),
               1, int'(next_rand()) % NUM_ADDR, next_rand(),
               1, int'(next_rand()) % NUM_ADDR, 1, int'(next_rand()) % NUM_ADDR);
    end
  endtask

  task automatic note_error();
    test_err++;
    err_total++;
  endtask

  task automatic drive_idle();
    write0 = 1'b0;
    write1 = 1'b0;
    read0  = 1'b0;
    read1  = 1'b0;
  endtask

  // reads see the model before this step's writes.
  task automatic apply_step(input step_t s);
    @(posedge clk);
    #1;
    if (!ready) begin
      $display("Error: test %s, ready is low while requests are being driven", s.name);
      note_error();
    end
    write0  = s.w0;
    wr_adr0 = s.wa0;
    din0    = s.d0;
    write1  = s.w1;
    wr_adr1 = s.wa1;
    din1    = s.d1;
    read0   = s.r0;
    rd_adr0 = s.ra0;
    read1   = s.r1;
    rd_adr1 = s.ra1;
    if (s.r0) exp_q0.push_back(model[s.ra0]);
    if (s.r1) exp_q1.push_back(model[s.ra1]);
    if (s.w0) model[s.wa0] = s.d0;
    if (s.w1) model[s.wa1] = s.d1;   // port 1 wins.
  endtask

  task automatic report_test();
    $display("test %s: %0d checks, %0d errors", cur_name, test_checks, test_err);
    test_checks = 0;
    test_err    = 0;
  endtask

  task automatic finish_test();
    @(posedge clk);
    #1;
    drive_idle();
    repeat (3) @(posedge clk);  // read latency plus one.
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      $display("Error: test %s ended with %0d reads that never returned data",
               cur_name, exp_q0.size() + exp_q1.size());
      note_error();
      exp_q0.delete();
      exp_q1.delete();
    end
    report_test();
  endtask

  task automatic check_init();
    int waited;
    @(negedge clk);
    test_checks++;
    checks_total++;
    if (ready) begin
      $display("Error: ready is high in the first cycle after reset");
      note_error();
    end
    waited = 0;
    while (!ready && waited < `MP_NUMVROW + 2) begin
      @(negedge clk);
      waited++;
    end
    test_checks++;
    checks_total++;
    if (!ready) begin
      $display("Error: ready did not rise within %0d cycles of reset", `MP_NUMVROW + 2);
      note_error();
    end
    report_test();
  endtask

  task automatic check_port(input int p, input logic [W-1:0] got);
    logic [W-1:0] exp;
    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
      $display("Error: test %s, port %0d returned data with no read pending", cur_name, p);
      note_error();
    end else begin
      if (p == 0) begin
        exp = exp_q0.pop_front();
      end else begin
        exp = exp_q1.pop_front();
      end
      test_checks++;
      checks_total++;
      if (got !== exp) begin
        $display("Mismatch: test %s port %0d expected %h actual %h", cur_name, p, exp, got);
        note_error();
      end
    end
  endtask

  always @(negedge clk) begin
    if (rd_vld0) check_port(0, rd_dout0);
    if (rd_vld1) check_port(1, rd_dout1);
  end

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    wr_adr0 = '0;
    wr_adr1 = '0;
    rd_adr0 = '0;
    rd_adr1 = '0;
    din0    = '0;
    din1    = '0;
    drive_idle();
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_init();
    for (int i = 0; i < steps.size(); i++) begin
      cur_name = steps[i].name;
      apply_step(steps[i]);
      if (i == steps.size() - 1 || steps[i + 1].name != steps[i].name) begin
        finish_test();
      end
    end
    $display("total: %0d checks, %0d errors", checks_total, err_total);
    if (err_total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (table_built);
    limit = 8 + `MP_NUMVROW + steps.size() + 4 * n_tests + 20;
    repeat (limit) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles before the tests finished", limit);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
mp_pkg.sv
mp_bank_ram.sv
mp_map_table.sv
mp_write_stage.sv
mp_read_stage.sv
mp_top.sv
mp_properties.sv
mp_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mp_tb -f files.f -o mp_sim
./obj_dir/mp_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
